// File: sources.f
+incdir+design
+incdir+verif
design/mips_pkg.sv
design/mips_decode.sv
design/mips_alu.sv
design/reg_file.sv
design/pc_counter.sv
design/mips_control.sv
design/mips_cpu_bus.sv
verif/mips_cpu_tb.sv

// File: Makefile
# Verilator flow for the multicycle MIPS core

VERILATOR  := verilator
TOP        := mips_cpu_tb
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
PASS_MSG   := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/mips_program.svh
/*
 * Test program for the MIPS core testbench
 * Instruction encoders, program image, data area,
 * expected store sequence and expected final v0
 */
`ifndef MIPS_PROGRAM_SVH
`define MIPS_PROGRAM_SVH

localparam int          PROG_LEN    = 46;
localparam logic [31:0] DATA_BASE   = 32'h1000_0000; // Built by LUI r8
localparam int          DATA_WORDS  = 32;
localparam int          STORE_COUNT = 5;
localparam logic [31:0] EXPECTED_V0 = 32'h7109_1F16; // Loads, shifts, ALU and compares

// Stores in program order, branch-skipped ones absent
localparam logic [31:0] STORE_ADDR [STORE_COUNT] = '{
    32'h1000_0000, 32'h1000_0004, 32'h1000_0008, 32'h1000_000C, 32'h1000_0010
};
localparam logic [31:0] STORE_DATA [STORE_COUNT] = '{
    32'h0000_9F0E, // r17 xor of and/or results
    32'h0008_0010, // r22 sll
    32'h00FF_FFFF, // r23 srl
    32'hFFFF_FFFD, // r24 sra
    32'h0000_6FF2  // r14 subu
};

function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] rd, input logic [4:0] sa,
                                       input logic [5:0] fn);
    return {6'd0, rs, rt, rd, sa, fn};
endfunction

function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// J to a program word, same 256 MB region as the reset vector
function automatic logic [31:0] jump_to(input logic [25:0] word_idx);
    return {6'd2, 26'h3F0_0000 + word_idx};
endfunction

function automatic logic [31:0] program_word(input int idx);
    case (idx)
        0:  return i_type(15, 0, 8, 16'h1000);   // lui   r8, 0x1000
        1:  return i_type(9, 0, 9, 16'hFFFB);    // addiu r9, r0, -5
        2:  return i_type(13, 0, 10, 16'h8001);  // ori   r10, r0, 0x8001
        3:  return i_type(12, 9, 11, 16'hF0F0);  // andi  r11, r9, 0xf0f0
        4:  return i_type(14, 10, 12, 16'h00FF); // xori  r12, r10, 0xff
        5:  return r_type(9, 10, 13, 0, 33);     // addu  r13, r9, r10
        6:  return r_type(11, 12, 14, 0, 35);    // subu  r14, r11, r12
        7:  return r_type(13, 14, 15, 0, 36);    // and   r15, r13, r14
        8:  return r_type(11, 12, 16, 0, 37);    // or    r16, r11, r12
        9:  return r_type(15, 16, 17, 0, 38);    // xor   r17, r15, r16
        10: return r_type(9, 10, 18, 0, 42);     // slt   r18, r9, r10
        11: return r_type(9, 10, 19, 0, 43);     // sltu  r19, r9, r10
        12: return i_type(10, 9, 20, 16'hFFFC);  // slti  r20, r9, -4
        13: return i_type(11, 10, 21, 16'hFFFF); // sltiu r21, r10, -1
        14: return r_type(0, 10, 22, 4, 0);      // sll   r22, r10, 4
        15: return r_type(0, 9, 23, 8, 2);       // srl   r23, r9, 8
        16: return r_type(0, 9, 24, 1, 3);       // sra   r24, r9, 1
        17: return i_type(43, 8, 17, 16'h0000);  // sw    r17, 0(r8)
        18: return i_type(4, 18, 20, 16'h0001);  // beq   taken
        19: return i_type(43, 8, 9, 16'h0040);   // Skipped store
        20: return i_type(43, 8, 22, 16'h0004);  // sw    r22, 4(r8)
        21: return i_type(4, 18, 19, 16'h0002);  // beq   not taken
        22: return i_type(43, 8, 23, 16'h0008);  // sw    r23, 8(r8)
        23: return jump_to(25);                  // j     over the beq target
        24: return i_type(43, 8, 9, 16'h0044);   // Beq target, never reached
        25: return i_type(5, 19, 20, 16'h0001);  // bne   taken
        26: return i_type(43, 8, 9, 16'h0048);   // Skipped store
        27: return i_type(43, 8, 24, 16'h000C);  // sw    r24, 12(r8)
        28: return i_type(5, 21, 20, 16'h0002);  // bne   not taken
        29: return i_type(43, 8, 14, 16'h0010);  // sw    r14, 16(r8)
        30: return jump_to(32);
        31: return i_type(43, 8, 9, 16'h004C);   // Bne target, never reached
        32: return i_type(35, 8, 25, 16'h0000);  // lw    r25, 0(r8)
        33: return i_type(35, 8, 26, 16'h000C);  // lw    r26, 12(r8)
        34: return r_type(25, 26, 2, 0, 33);     // addu  v0, r25, r26
        35: return r_type(2, 22, 2, 0, 38);      // xor   v0, v0, r22
        36: return r_type(2, 23, 2, 0, 33);      // addu  v0, v0, r23
        37: return r_type(2, 13, 2, 0, 33);      // addu  v0, v0, r13
        38: return r_type(0, 20, 3, 1, 0);       // sll   r3, r20, 1
        39: return r_type(3, 18, 3, 0, 37);      // or    r3, r3, r18
        40: return r_type(0, 21, 4, 2, 0);       // sll   r4, r21, 2
        41: return r_type(3, 4, 3, 0, 38);       // xor   r3, r3, r4
        42: return r_type(3, 19, 3, 0, 33);      // addu  r3, r3, r19
        43: return r_type(0, 3, 3, 28, 0);       // Compare bits to the top nibble
        44: return r_type(2, 3, 2, 0, 33);       // addu  v0, v0, r3
        45: return r_type(0, 0, 0, 0, 8);        // jr    r0, halts
        default: return 32'h0000_0000;
    endcase
endfunction

`endif

// File: verif/mips_cpu_tb.sv
/*
 * Testbench for the multicycle MIPS core
 * Clock and reset, memory model with random waitrequest,
 * bus, store and halt assertions, timeout
 */
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_cpu_tb;

    `include "mips_program.svh"

    localparam int CYCLE_LIMIT = PROG_LEN * 3 * 4; // Three cycles per word, four times for stalls

    logic                     clk;
    logic                     reset;
    logic                     active;
    logic [`MIPS_DATA_W-1:0]  register_v0;
    logic [`MIPS_DATA_W-1:0]  address;
    logic                     write;
    logic                     read;
    logic                     waitrequest;
    logic [`MIPS_DATA_W-1:0]  writedata;
    logic [`MIPS_BYTES_W-1:0] byteenable;
    logic [`MIPS_DATA_W-1:0]  readdata;

    logic [31:0] prog_mem [PROG_LEN];
    logic [31:0] data_mem [DATA_WORDS];
    logic [31:0] prev_address;
    logic [31:0] prev_writedata;
    logic        prev_read;
    logic        prev_write;
    logic        prev_waitrequest;
    logic        prev_active;
    logic        started = 1'b0;
    logic        first_read_seen = 1'b0;
    logic        write_stall_seen = 1'b0;
    logic        halted = 1'b0;
    int          store_idx = 0;
    int          cycle_count = 0;

    mips_cpu_bus u_mips_cpu_bus (
        .clk, .reset, .active, .register_v0, .address, .write, .read,
        .waitrequest, .writedata, .byteenable, .readdata
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("mismatch at time %0t: %s", $time, msg));
    endtask

    // Swapped halves mixed with a constant so every address bit counts
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - `MIPS_RESET_VECTOR;
        if (offset < 4 * PROG_LEN)
            return prog_mem[offset >> 2];
        offset = addr - DATA_BASE;
        if (offset < 4 * DATA_WORDS)
            return data_mem[offset >> 2];
        return fill_word(addr);
    endfunction

    task automatic load_memory();
        for (int i = 0; i < PROG_LEN; i++)
            prog_mem[i] = program_word(i);
        for (int i = 0; i < DATA_WORDS; i++)
            data_mem[i] = fill_word(DATA_BASE + 4 * i);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        void'($urandom(7));
        reset       = 1'b1;
        waitrequest = 1'b0;
        readdata    = '0;
        load_memory();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait (halted);
        repeat (10) @(posedge clk); // Core must stay idle
        $display("Done: no errors");
        $finish;
    end

    // Slave side driven on the falling edge
    always @(negedge clk) begin
        waitrequest = (($urandom % 3) == 0) ||     // Stall about one cycle in three
                      (write && !write_stall_seen); // First store always waits once
        if (write && waitrequest)
            write_stall_seen = 1'b1;
        readdata = mem_read(address);
    end

    always @(posedge clk) begin
        if (!reset && write && !waitrequest && (address - DATA_BASE < 4 * DATA_WORDS))
            data_mem[(address - DATA_BASE) >> 2] <= writedata;
    end

    always @(posedge clk) begin
        if (!reset) begin
            cycle_count++;
            if (cycle_count > CYCLE_LIMIT)
                abort_run($sformatf("timeout: core did not halt within %0d cycles", CYCLE_LIMIT));
            if (!started)
                assert (active && read && !write) else report_mismatch("not fetching after reset");
            assert (!(read && write)) else report_mismatch("read and write high together");
            if (read) begin
                assert (address[1:0] == 2'b00)
                    else report_mismatch($sformatf("unaligned read at %h", address));
                if (!first_read_seen)
                    assert (address == `MIPS_RESET_VECTOR)
                        else report_mismatch($sformatf("first fetch at %h", address));
                first_read_seen = 1'b1;
            end
            // Held request while the slave stalls
            if (started && prev_waitrequest && (prev_read || prev_write))
                assert (address == prev_address && read == prev_read && write == prev_write)
                    else report_mismatch("request changed during waitrequest");
            if (started && prev_waitrequest && prev_write)
                assert (writedata == prev_writedata)
                    else report_mismatch("writedata changed during waitrequest");
            if (write && !waitrequest) begin
                assert (byteenable == 4'hF)
                    else report_mismatch($sformatf("byteenable %h", byteenable));
                assert (store_idx < STORE_COUNT)
                    else report_mismatch($sformatf("extra store to %h", address));
                assert (address == STORE_ADDR[store_idx])
                    else report_mismatch($sformatf("store %0d address %h, expected %h",
                                                   store_idx, address, STORE_ADDR[store_idx]));
                assert (writedata == STORE_DATA[store_idx])
                    else report_mismatch($sformatf("store %0d data %h, expected %h",
                                                   store_idx, writedata, STORE_DATA[store_idx]));
                store_idx++;
            end
            if (started && prev_active && !active) begin
                assert (register_v0 == EXPECTED_V0)
                    else report_mismatch($sformatf("v0 %h, expected %h", register_v0, EXPECTED_V0));
                assert (store_idx == STORE_COUNT)
                    else report_mismatch($sformatf("halt after %0d of %0d stores",
                                                   store_idx, STORE_COUNT));
                halted = 1'b1;
            end
            if (halted)
                assert (!active && !read && !write) else report_mismatch("bus active after halt");
            prev_address     = address;
            prev_writedata   = writedata;
            prev_read        = read;
            prev_write       = write;
            prev_waitrequest = waitrequest;
            prev_active      = active;
            started          = 1'b1;
        end
    end

endmodule

// File: design/mips_cpu_bus.sv
/*
 * Top level of the multicycle MIPS core
 * Control, decode, ALU, register file and pc wiring
 * with the Avalon master port
 */
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_cpu_bus (
    input  logic                     clk,
    input  logic                     reset,
    output logic                     active,
    output logic [`MIPS_DATA_W-1:0]  register_v0,
    output logic [`MIPS_DATA_W-1:0]  address,
    output logic                     write,
    output logic                     read,
    input  logic                     waitrequest,
    output logic [`MIPS_DATA_W-1:0]  writedata,
    output logic [`MIPS_BYTES_W-1:0] byteenable,
    input  logic [`MIPS_DATA_W-1:0]  readdata
);

    mips_pkg::decoded_t      dec;
    mips_pkg::bus_req_t      bus;
    logic [`MIPS_DATA_W-1:0] instr;
    logic [`MIPS_DATA_W-1:0] pc;
    logic [`MIPS_DATA_W-1:0] pc_target;
    logic [`MIPS_DATA_W-1:0] rs_data;
    logic [`MIPS_DATA_W-1:0] rt_data;
    logic [`MIPS_DATA_W-1:0] alu_b;
    logic [`MIPS_DATA_W-1:0] alu_result;
    logic [`MIPS_DATA_W-1:0] wr_data;
    logic                    branch_taken;
    logic                    reg_write;
    logic                    wb_from_mem;
    logic                    pc_step;
    logic                    pc_load;

    assign alu_b   = dec.use_imm ? dec.imm : rt_data;
    assign wr_data = wb_from_mem ? readdata : alu_result; // LW data or ALU result

    mips_control u_mips_control (
        .clk, .reset, .dec, .pc, .alu_result, .branch_taken, .rs_data, .rt_data,
        .waitrequest, .readdata, .instr, .bus, .reg_write, .wb_from_mem,
        .pc_step, .pc_load, .pc_target, .active
    );

    mips_decode u_mips_decode (.instr, .dec);

    mips_alu u_mips_alu (
        .op(dec.alu_op), .a(rs_data), .b(alu_b), .shamt(dec.shamt),
        .result(alu_result), .branch_ne(dec.branch_ne), .branch_taken
    );

    reg_file u_reg_file (
        .clk, .reset, .rs_addr(dec.rs), .rt_addr(dec.rt), .rs_data, .rt_data,
        .wr_en(reg_write), .wr_addr(dec.dest), .wr_data, .v0(register_v0)
    );

    pc_counter u_pc_counter (
        .clk, .reset, .step(pc_step), .load(pc_load), .load_addr(pc_target), .pc
    );

    // Avalon master port
    assign address    = bus.address;
    assign read       = bus.read;
    assign write      = bus.write;
    assign writedata  = bus.writedata;
    assign byteenable = bus.byteenable;

endmodule

// File: design/mips_control.sv
/*
 * Control FSM of the multicycle MIPS core
 * FETCH, EXEC, MEM and HALT states, instruction register,
 * bus request, write enables and pc update strobes
 */
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_control (
    input  logic                    clk,
    input  logic                    reset,
    input  mips_pkg::decoded_t      dec,
    input  logic [`MIPS_DATA_W-1:0] pc,
    input  logic [`MIPS_DATA_W-1:0] alu_result,
    input  logic                    branch_taken,
    input  logic [`MIPS_DATA_W-1:0] rs_data,
    input  logic [`MIPS_DATA_W-1:0] rt_data,
    input  logic                    waitrequest,
    input  logic [`MIPS_DATA_W-1:0] readdata,
    output logic [`MIPS_DATA_W-1:0] instr,
    output mips_pkg::bus_req_t      bus,
    output logic                    reg_write,
    output logic                    wb_from_mem,
    output logic                    pc_step,
    output logic                    pc_load,
    output logic [`MIPS_DATA_W-1:0] pc_target,
    output logic                    active
);

    mips_pkg::state_t state;
    mips_pkg::state_t state_next;
    logic             is_load;
    logic             is_store;
    logic             at_halt;    // pc reached the halt address
    logic             fetch_done; // Instruction word arrives this cycle

    assign is_load    = (dec.cls == mips_pkg::CLS_LOAD);
    assign is_store   = (dec.cls == mips_pkg::CLS_STORE);
    assign at_halt    = (pc == `MIPS_HALT_ADDR);
    assign fetch_done = (state == mips_pkg::FETCH) && !at_halt && !waitrequest;

    always_comb begin
        state_next = state; // Waitrequest holds the state
        case (state)
            mips_pkg::FETCH:
                if (at_halt)
                    state_next = mips_pkg::HALT;
                else if (!waitrequest)
                    state_next = mips_pkg::EXEC;
            mips_pkg::EXEC:
                state_next = (is_load || is_store) ? mips_pkg::MEM : mips_pkg::FETCH;
            mips_pkg::MEM:
                if (!waitrequest)
                    state_next = mips_pkg::FETCH;
            default: ; // HALT until reset
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= mips_pkg::FETCH;
            active <= 1'b1;
        end else begin
            state <= state_next;
            if (state_next == mips_pkg::HALT)
                active <= 1'b0;
        end
    end

    // Instruction register, loaded once per fetch
    always_ff @(posedge clk) begin
        if (fetch_done)
            instr <= readdata;
    end

    // Bus request, stable while waitrequest is high
    always_comb begin
        bus.address    = pc;
        bus.read       = 1'b0;
        bus.write      = 1'b0;
        bus.writedata  = rt_data;
        bus.byteenable = '1; // Word accesses only
        case (state)
            mips_pkg::FETCH:
                bus.read = !at_halt;
            mips_pkg::MEM: begin
                bus.address = alu_result;   // Base plus offset
                bus.read    = is_load;
                bus.write   = is_store;
            end
            default: ;
        endcase
    end

    // Branch offset is relative to the word after the branch
    always_comb begin
        case (dec.cls)
            mips_pkg::CLS_JUMP:
                pc_target = {pc[`MIPS_DATA_W-1:`MIPS_TARGET_W+2], dec.target, 2'b00};
            mips_pkg::CLS_JUMP_REG:
                pc_target = rs_data;
            default:
                pc_target = pc + (dec.imm << 2);
        endcase
    end

    assign pc_step = fetch_done;
    assign pc_load = (state == mips_pkg::EXEC) &&
                     ((dec.cls == mips_pkg::CLS_JUMP) || (dec.cls == mips_pkg::CLS_JUMP_REG) ||
                      ((dec.cls == mips_pkg::CLS_BRANCH) && branch_taken));

    // ALU results in EXEC, load data when the read completes
    assign reg_write = dec.write_reg &&
                       (((state == mips_pkg::EXEC) && (dec.cls == mips_pkg::CLS_ALU)) ||
                        ((state == mips_pkg::MEM) && is_load && !waitrequest));
    assign wb_from_mem = (state == mips_pkg::MEM);

endmodule

// File: design/pc_counter.sv
/*
 * Program counter
 * Reset vector, sequential step of one word, branch and jump load
 */
`timescale 1ns/1ps
`include "mips_params.svh"

module pc_counter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    step,
    input  logic                    load,
    input  logic [`MIPS_DATA_W-1:0] load_addr,
    output logic [`MIPS_DATA_W-1:0] pc
);

    always_ff @(posedge clk) begin
        if (reset)
            pc <= `MIPS_RESET_VECTOR;
        else if (load)           // Taken branch or jump has priority
            pc <= load_addr;
        else if (step)
            pc <= pc + `MIPS_DATA_W'd4;
    end

endmodule

// File: design/reg_file.sv
/*
 * General purpose register file
 * 32 words, two combinational reads, one clocked write, r0 fixed at zero
 */
`timescale 1ns/1ps
`include "mips_params.svh"

module reg_file (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`MIPS_REG_ADDR_W-1:0] rs_addr,
    input  logic [`MIPS_REG_ADDR_W-1:0] rt_addr,
    output logic [`MIPS_DATA_W-1:0]     rs_data,
    output logic [`MIPS_DATA_W-1:0]     rt_data,
    input  logic                        wr_en,
    input  logic [`MIPS_REG_ADDR_W-1:0] wr_addr,
    input  logic [`MIPS_DATA_W-1:0]     wr_data,
    output logic [`MIPS_DATA_W-1:0]     v0
);

    logic [`MIPS_DATA_W-1:0] regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wr_en && (wr_addr != '0)) begin // r0 never written
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign v0      = regs[`MIPS_V0_REG];           // Exported result

endmodule

// File: design/mips_alu.sv
/*
 * ALU for the multicycle MIPS core
 * Add, subtract, logic, shifts, compares, LUI and the branch condition
 */
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_alu (
    input  mips_pkg::alu_op_t           op,
    input  logic [`MIPS_DATA_W-1:0]     a,
    input  logic [`MIPS_DATA_W-1:0]     b,
    input  logic [`MIPS_REG_ADDR_W-1:0] shamt,
    output logic [`MIPS_DATA_W-1:0]     result,
    input  logic                        branch_ne,
    output logic                        branch_taken
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            mips_pkg::ALU_ADD:  result = a + b;
            mips_pkg::ALU_SUB:  result = a - b;
            mips_pkg::ALU_AND:  result = a & b;
            mips_pkg::ALU_OR:   result = a | b;
            mips_pkg::ALU_XOR:  result = a ^ b;
            mips_pkg::ALU_SLT:  result = {{(`MIPS_DATA_W-1){1'b0}}, lt_signed};
            mips_pkg::ALU_SLTU: result = {{(`MIPS_DATA_W-1){1'b0}}, lt_unsigned};
            mips_pkg::ALU_SLL:  result = b << shamt;
            mips_pkg::ALU_SRL:  result = b >> shamt;
            mips_pkg::ALU_SRA:  result = $signed(b) >>> shamt; // Keeps the sign bit
            mips_pkg::ALU_LUI:  result = {b[`MIPS_IMM_W-1:0], {`MIPS_IMM_W{1'b0}}};
            default:            result = b;                    // Pass-b
        endcase
    end

    // Equal for BEQ, unequal for BNE
    assign branch_taken = branch_ne ? (a != b) : (a == b);

endmodule

// File: design/mips_decode.sv
/*
 * Instruction decoder
 * Field split, class and ALU operation, destination choice, immediate extension
 */
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_decode (
    input  logic [`MIPS_DATA_W-1:0] instr,
    output mips_pkg::decoded_t      dec
);

    mips_pkg::opcode_t      op;
    mips_pkg::funct_t       fn;
    logic [`MIPS_IMM_W-1:0] imm16;
    logic                   zero_ext; // Logical immediates

    assign op    = mips_pkg::opcode_t'(instr[`MIPS_OP_LSB +: `MIPS_OP_W]);
    assign fn    = mips_pkg::funct_t'(instr[`MIPS_FUNCT_W-1:0]);
    assign imm16 = instr[`MIPS_IMM_W-1:0];

    always_comb begin
        zero_ext          = 1'b0;
        dec.cls           = mips_pkg::CLS_ILLEGAL; // Unknown runs as a no-op
        dec.alu_op        = mips_pkg::ALU_PASS_B;
        dec.rs            = instr[`MIPS_RS_LSB +: `MIPS_REG_ADDR_W];
        dec.rt            = instr[`MIPS_RT_LSB +: `MIPS_REG_ADDR_W];
        dec.dest          = instr[`MIPS_RT_LSB +: `MIPS_REG_ADDR_W]; // I-type writes rt
        dec.shamt         = instr[`MIPS_SHAMT_LSB +: `MIPS_REG_ADDR_W];
        dec.target        = instr[`MIPS_TARGET_W-1:0];
        dec.use_imm       = 1'b1;
        dec.write_reg     = 1'b0;
        dec.branch_ne     = 1'b0;
        case (op)
            mips_pkg::OP_RTYPE: begin
                dec.dest      = instr[`MIPS_RD_LSB +: `MIPS_REG_ADDR_W];
                dec.use_imm   = 1'b0;
                dec.cls       = mips_pkg::CLS_ALU;
                dec.write_reg = 1'b1;
                case (fn)
                    mips_pkg::FN_ADDU: dec.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: dec.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  dec.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   dec.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  dec.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  dec.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: dec.alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::FN_SLL:  dec.alu_op = mips_pkg::ALU_SLL; // Shifts act on rt
                    mips_pkg::FN_SRL:  dec.alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::FN_SRA:  dec.alu_op = mips_pkg::ALU_SRA;
                    mips_pkg::FN_JR: begin
                        dec.cls       = mips_pkg::CLS_JUMP_REG;
                        dec.write_reg = 1'b0;
                    end
                    default: begin
                        dec.cls       = mips_pkg::CLS_ILLEGAL;
                        dec.write_reg = 1'b0;
                    end
                endcase
            end
            mips_pkg::OP_J:
                dec.cls = mips_pkg::CLS_JUMP;
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                dec.cls       = mips_pkg::CLS_BRANCH;
                dec.alu_op    = mips_pkg::ALU_SUB;
                dec.use_imm   = 1'b0;       // Compare rs against rt
                dec.branch_ne = (op == mips_pkg::OP_BNE);
            end
            mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU,
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI,
            mips_pkg::OP_LUI: begin
                dec.cls       = mips_pkg::CLS_ALU;
                dec.write_reg = 1'b1;
                case (op)
                    mips_pkg::OP_ADDIU: dec.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::OP_SLTI:  dec.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::OP_SLTIU: dec.alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::OP_ANDI:  dec.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::OP_ORI:   dec.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::OP_XORI:  dec.alu_op = mips_pkg::ALU_XOR;
                    default:            dec.alu_op = mips_pkg::ALU_LUI;
                endcase
                zero_ext = (op == mips_pkg::OP_ANDI) || (op == mips_pkg::OP_ORI) ||
                           (op == mips_pkg::OP_XORI);
            end
            mips_pkg::OP_LW: begin
                dec.cls       = mips_pkg::CLS_LOAD;
                dec.alu_op    = mips_pkg::ALU_ADD; // Base plus offset
                dec.write_reg = 1'b1;
            end
            mips_pkg::OP_SW: begin
                dec.cls    = mips_pkg::CLS_STORE;
                dec.alu_op = mips_pkg::ALU_ADD;
            end
            default: ;
        endcase
        // Sign extension unless a logical immediate
        dec.imm = zero_ext ? {{(`MIPS_DATA_W-`MIPS_IMM_W){1'b0}}, imm16}
                           : {{(`MIPS_DATA_W-`MIPS_IMM_W){imm16[`MIPS_IMM_W-1]}}, imm16};
    end

endmodule

// File: design/mips_pkg.sv
/*
 * Types for the multicycle MIPS core
 * Opcode, function code, ALU operation, FSM state and instruction class enums
 * Decoded instruction and bus request structs
 */
`include "mips_params.svh"

package mips_pkg;

    // Kept main opcodes, standard MIPS encoding
    typedef enum logic [`MIPS_OP_W-1:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_t;

    // R-type function codes
    typedef enum logic [`MIPS_FUNCT_W-1:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {FETCH, EXEC, MEM, HALT} state_t;

    typedef enum logic [2:0] {
        CLS_ALU, CLS_BRANCH, CLS_JUMP, CLS_JUMP_REG, CLS_LOAD, CLS_STORE, CLS_ILLEGAL
    } instr_class_t;

    typedef struct packed {
        instr_class_t                cls;
        alu_op_t                     alu_op;
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        logic [`MIPS_REG_ADDR_W-1:0] dest;      // rd for R-type, rt otherwise
        logic [`MIPS_REG_ADDR_W-1:0] shamt;
        logic [`MIPS_DATA_W-1:0]     imm;       // Already extended
        logic [`MIPS_TARGET_W-1:0]   target;
        logic                        use_imm;   // ALU b from imm
        logic                        write_reg;
        logic                        branch_ne; // BNE rather than BEQ
    } decoded_t;

    typedef struct packed {
        logic [`MIPS_DATA_W-1:0]  address;
        logic                     read;
        logic                     write;
        logic [`MIPS_DATA_W-1:0]  writedata;
        logic [`MIPS_BYTES_W-1:0] byteenable;
    } bus_req_t;

endpackage

// File: design/mips_params.svh
/*
 * Shared constants for the multicycle MIPS core
 * Datapath widths, reset and halt addresses, register indices
 * and bit positions of the instruction fields
 */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

`define MIPS_DATA_W        32            // Data and address width
`define MIPS_REG_ADDR_W    5
`define MIPS_REG_COUNT     32
`define MIPS_RESET_VECTOR  32'hBFC00000  // First fetch after reset
`define MIPS_HALT_ADDR     32'h00000000  // Fetching here stops the core
`define MIPS_V0_REG        2             // Exported result register
`define MIPS_IMM_W         16
`define MIPS_TARGET_W      26
`define MIPS_BYTES_W       4             // Byteenable lanes

// Instruction field layout
`define MIPS_OP_W          6
`define MIPS_FUNCT_W       6
`define MIPS_OP_LSB        26
`define MIPS_RS_LSB        21
`define MIPS_RT_LSB        16
`define MIPS_RD_LSB        11
`define MIPS_SHAMT_LSB     6

`endif
